//--- hdl/core_req_pkg.sv
// core side types: remote request, load info and atomic type
`include "net_consts.svh"

package core_req_pkg;

  typedef enum logic [2:0] {
    e_amo_swap = 3'd0,
    e_amo_or   = 3'd1,
    e_amo_add  = 3'd2,
    e_amo_min  = 3'd3,
    e_amo_max  = 3'd4,
    e_amo_minu = 3'd5,
    e_amo_maxu = 3'd6
  } amo_e;

  typedef struct packed {
    logic       icache_fetch;
    logic       float_wb;
    logic       is_unsigned;
    logic [1:0] size;
  } load_info_s;

  typedef struct packed {
    logic                     write_not_read;
    logic                     is_amo_op;
    amo_e                     amo_type;
    logic [3:0]               mask;
    logic [`NET_REG_ID_W-1:0] reg_id;
    load_info_s               load_info;
    logic [31:0]              addr;     // eva
    logic [`NET_DATA_W-1:0]   data;
  } remote_req_s;

endpackage

//--- hdl/eva_to_npa.sv
// eva to network physical address translation
`timescale 1ns/100ps
`include "net_consts.svh"

module eva_to_npa (
  input  logic [31:0]               eva_i,
  input  logic [`NET_SUBX_W-1:0]    tgo_x_i,
  input  logic [`NET_SUBY_W-1:0]    tgo_y_i,
  input  logic [`NET_POD_X_W-1:0]   pod_x_i,
  input  logic [`NET_POD_Y_W-1:0]   pod_y_i,
  output logic [`NET_X_W-1:0]       x_o,
  output logic [`NET_Y_W-1:0]       y_o,
  output logic [`NET_ADDR_W-1:0]    epa_o,
  output logic                      invalid_o
);

  localparam int OFS_W = $clog2(`NET_VC_BLOCK_WORDS);
  localparam int COL_W = $clog2(`NET_TILES_X);

  logic [28:0]              word_addr;
  logic [`NET_POD_Y_W-1:0]  north_pod_y;
  logic [`NET_SUBX_W:0]     grp_x;
  logic [`NET_SUBY_W:0]     grp_y;

  assign word_addr   = eva_i[30:2];
  // north vcache row sits one pod row up
  assign north_pod_y = pod_y_i - `NET_POD_Y_W'(1);

  // tile group offsets at eva[24:22] (y) and eva[21:18] (x)
  assign grp_x = {1'b0, tgo_x_i} + {1'b0, eva_i[21:18]};
  assign grp_y = {1'b0, tgo_y_i} + {1'b0, eva_i[24:22]};

  always_comb begin
    x_o       = '0;
    y_o       = '0;
    epa_o     = '0;
    invalid_o = 1'b0;

    if (eva_i[31]) begin
      // dram, blocks striped over the columns
      x_o   = {pod_x_i, word_addr[OFS_W +: COL_W]};
      y_o   = {north_pod_y, `NET_SUBY_W'(0)};
      epa_o = `NET_ADDR_W'({word_addr[28:OFS_W+COL_W], word_addr[OFS_W-1:0]});
    end else if (eva_i[31:30] == 2'b01) begin
      // global
      y_o   = eva_i[29:23];
      x_o   = eva_i[22:16];
      epa_o = `NET_ADDR_W'(eva_i[15:2]);
    end else if (eva_i[31:29] == 3'b001) begin
      x_o   = {pod_x_i, grp_x[`NET_SUBX_W-1:0]};
      y_o   = {pod_y_i, grp_y[`NET_SUBY_W-1:0]};
      epa_o = `NET_ADDR_W'(eva_i[17:2]);
      // group reaches past the tile array
      invalid_o = (grp_x >= `NET_TILES_X) || (grp_y >= `NET_TILES_Y);
    end else begin
      invalid_o = 1'b1;
    end
  end

endmodule

//--- hdl/net_ifs.sv
// remote request and return queue interfaces
`timescale 1ns/100ps

// valid-credit request path from the core
interface remote_req_if;
  logic                      valid;
  core_req_pkg::remote_req_s req;
  logic                      credit;

  modport core (
    output valid,
    output req,
    input  credit
  );

  modport tx (
    input  valid,
    input  req,
    output credit
  );
endinterface

// head of the return queue, yumi pops it
interface return_if;
  logic              v;
  net_pkg::net_ret_s ret;
  logic              full;
  logic              yumi;

  modport queue (
    output v,
    output ret,
    output full,
    input  yumi
  );

  modport tx (
    input  v,
    input  ret,
    input  full,
    output yumi
  );
endinterface

//--- hdl/net_pkg.sv
// network side types: request packet, op code and return packet
`include "net_consts.svh"

package net_pkg;

  // remote op carried in the request packet
  typedef enum logic [3:0] {
    e_op_load    = 4'd0,
    e_op_store   = 4'd1,
    e_op_amoswap = 4'd2,
    e_op_amoor   = 4'd3,
    e_op_amoadd  = 4'd4,
    e_op_amomin  = 4'd5,
    e_op_amomax  = 4'd6,
    e_op_amominu = 4'd7,
    e_op_amomaxu = 4'd8
  } net_op_e;

  typedef struct packed {
    logic [`NET_DATA_W-1:0]   payload;
    logic [`NET_Y_W-1:0]      src_y;
    logic [`NET_X_W-1:0]      src_x;
    logic [`NET_Y_W-1:0]      y;
    logic [`NET_X_W-1:0]      x;
    net_op_e                  op;
    logic [`NET_REG_ID_W-1:0] reg_id;
    logic [`NET_ADDR_W-1:0]   addr;
  } net_packet_s;

  typedef enum logic [1:0] {
    e_ret_int_wb   = 2'd0,
    e_ret_float_wb = 2'd1,
    e_ret_ifetch   = 2'd2,
    e_ret_credit   = 2'd3
  } net_ret_type_e;

  typedef struct packed {
    logic [`NET_DATA_W-1:0]   data;
    logic [`NET_REG_ID_W-1:0] reg_id;
    net_ret_type_e            pkt_type;
  } net_ret_s;

endpackage

//--- hdl/net_tx.sv
// request packet builder, credit path and response dispatch
`timescale 1ns/100ps
`include "net_consts.svh"

module net_tx (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  remote_req_if.tx                      req,
  return_if.tx                          ret,
  input  logic [`NET_SUBX_W-1:0]        tgo_x_i,
  input  logic [`NET_SUBY_W-1:0]        tgo_y_i,
  input  logic [`NET_SUBX_W-1:0]        my_x_i,
  input  logic [`NET_SUBY_W-1:0]        my_y_i,
  input  logic [`NET_POD_X_W-1:0]       pod_x_i,
  input  logic [`NET_POD_Y_W-1:0]       pod_y_i,
  input  logic [`NET_POD_X_W-1:0]       cfg_pod_x_i,
  input  logic [`NET_POD_Y_W-1:0]       cfg_pod_y_i,
  input  logic                          out_credit_i,
  output net_pkg::net_packet_s          out_packet_o,
  output logic                          out_v_o,
  output logic                          invalid_eva_o,
  output logic                          ifetch_v_o,
  output logic [`NET_DATA_W-1:0]        ifetch_instr_o,
  output logic                          int_resp_v_o,
  output logic [`NET_REG_ID_W-1:0]      int_resp_rd_o,
  output logic [`NET_DATA_W-1:0]        int_resp_data_o,
  output logic                          int_resp_force_o,
  input  logic                          int_resp_yumi_i,
  output logic                          float_resp_v_o,
  output logic [`NET_REG_ID_W-1:0]      float_resp_rd_o,
  output logic [`NET_DATA_W-1:0]        float_resp_data_o,
  output logic                          float_resp_force_o,
  input  logic                          float_resp_yumi_i
);

  localparam int INFO_W = $bits(core_req_pkg::load_info_s);

  logic [`NET_X_W-1:0]    x_lo;
  logic [`NET_Y_W-1:0]    y_lo;
  logic [`NET_ADDR_W-1:0] epa_lo;
  logic                   invalid_lo;
  logic                   is_fetch;

  // icache fetches ignore pod rehoming
  assign is_fetch = req.req.load_info.icache_fetch;

  eva_to_npa u_eva_to_npa (
    .eva_i     (req.req.addr),
    .tgo_x_i   (tgo_x_i),
    .tgo_y_i   (tgo_y_i),
    .pod_x_i   (is_fetch ? pod_x_i : cfg_pod_x_i),
    .pod_y_i   (is_fetch ? pod_y_i : cfg_pod_y_i),
    .x_o       (x_lo),
    .y_o       (y_lo),
    .epa_o     (epa_lo),
    .invalid_o (invalid_lo)
  );

  always_comb begin
    if (req.req.write_not_read || req.req.is_amo_op) begin
      out_packet_o.payload = req.req.data;
    end else begin
      out_packet_o.payload = {{(`NET_DATA_W-INFO_W){1'b0}}, req.req.load_info};
    end

    // stores carry the byte mask in reg_id
    if (req.req.write_not_read) begin
      out_packet_o.reg_id = {{(`NET_REG_ID_W-4){1'b0}}, req.req.mask};
    end else begin
      out_packet_o.reg_id = req.req.reg_id;
    end

    out_packet_o.src_y = {pod_y_i, my_y_i};
    out_packet_o.src_x = {pod_x_i, my_x_i};
    out_packet_o.y     = y_lo;
    out_packet_o.x     = x_lo;
    out_packet_o.addr  = epa_lo;

    if (req.req.is_amo_op) begin
      case (req.req.amo_type)
        core_req_pkg::e_amo_or:   out_packet_o.op = net_pkg::e_op_amoor;
        core_req_pkg::e_amo_add:  out_packet_o.op = net_pkg::e_op_amoadd;
        core_req_pkg::e_amo_min:  out_packet_o.op = net_pkg::e_op_amomin;
        core_req_pkg::e_amo_max:  out_packet_o.op = net_pkg::e_op_amomax;
        core_req_pkg::e_amo_minu: out_packet_o.op = net_pkg::e_op_amominu;
        core_req_pkg::e_amo_maxu: out_packet_o.op = net_pkg::e_op_amomaxu;
        default:                  out_packet_o.op = net_pkg::e_op_amoswap;
      endcase
    end else if (req.req.write_not_read) begin
      out_packet_o.op = net_pkg::e_op_store;
    end else begin
      out_packet_o.op = net_pkg::e_op_load;
    end
  end

  assign out_v_o       = req.valid & ~invalid_lo;
  assign invalid_eva_o = req.valid & invalid_lo;
  assign req.credit    = out_credit_i;

  // head fields go to every port, valids select one
  assign ifetch_instr_o    = ret.ret.data;
  assign int_resp_data_o   = ret.ret.data;
  assign int_resp_rd_o     = ret.ret.reg_id;
  assign float_resp_data_o = ret.ret.data;
  assign float_resp_rd_o   = ret.ret.reg_id;

  always_comb begin
    ifetch_v_o         = 1'b0;
    int_resp_v_o       = 1'b0;
    int_resp_force_o   = 1'b0;
    float_resp_v_o     = 1'b0;
    float_resp_force_o = 1'b0;

    case (ret.ret.pkt_type)
      net_pkg::e_ret_ifetch: begin
        ifetch_v_o = ret.v;
        ret.yumi   = ret.v;
      end
      net_pkg::e_ret_float_wb: begin
        float_resp_v_o     = ret.v;
        float_resp_force_o = ret.full;
        ret.yumi           = float_resp_yumi_i | ret.full;
      end
      default: begin
        int_resp_v_o     = ret.v;
        int_resp_force_o = ret.full;
        ret.yumi         = int_resp_yumi_i | ret.full;
      end
    endcase
  end

  // credits are consumed before the queue
  a_no_credit_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret.v |-> ret.ret.pkt_type != net_pkg::e_ret_credit);

endmodule

//--- hdl/return_fifo.sv
// return packet queue, valid/ready in and yumi out
`timescale 1ns/100ps
`include "net_consts.svh"

module return_fifo (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_v_i,
  input  net_pkg::net_ret_s in_ret_i,
  output logic              in_ready_o,
  return_if.queue           q
);

  localparam int DEPTH = `RET_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  net_pkg::net_ret_s mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  assign q.full     = (count == CNT_W'(DEPTH));
  assign q.v        = (count != '0);
  assign q.ret      = mem[rd_ptr];
  assign in_ready_o = ~q.full;

  assign push = in_v_i & in_ready_o;
  assign pop  = q.yumi;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_ret_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    q.yumi |-> q.v);

endmodule

//--- hdl/tile_net_endpoint.sv
// tile network endpoint top, return queue plus request/response logic
`timescale 1ns/100ps
`include "net_consts.svh"

module tile_net_endpoint (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  core_req_pkg::remote_req_s     remote_req_i,
  input  logic                          remote_req_v_i,
  output logic                          remote_req_credit_o,
  input  logic                          ret_v_i,
  input  net_pkg::net_ret_s             ret_i,
  output logic                          ret_ready_o,
  input  logic [`NET_SUBX_W-1:0]        tgo_x_i,
  input  logic [`NET_SUBY_W-1:0]        tgo_y_i,
  input  logic [`NET_SUBX_W-1:0]        my_x_i,
  input  logic [`NET_SUBY_W-1:0]        my_y_i,
  input  logic [`NET_POD_X_W-1:0]       pod_x_i,
  input  logic [`NET_POD_Y_W-1:0]       pod_y_i,
  input  logic [`NET_POD_X_W-1:0]       cfg_pod_x_i,
  input  logic [`NET_POD_Y_W-1:0]       cfg_pod_y_i,
  input  logic                          out_credit_i,
  output net_pkg::net_packet_s          out_packet_o,
  output logic                          out_v_o,
  output logic                          invalid_eva_o,
  output logic                          ifetch_v_o,
  output logic [`NET_DATA_W-1:0]        ifetch_instr_o,
  output logic                          int_resp_v_o,
  output logic [`NET_REG_ID_W-1:0]      int_resp_rd_o,
  output logic [`NET_DATA_W-1:0]        int_resp_data_o,
  output logic                          int_resp_force_o,
  input  logic                          int_resp_yumi_i,
  output logic                          float_resp_v_o,
  output logic [`NET_REG_ID_W-1:0]      float_resp_rd_o,
  output logic [`NET_DATA_W-1:0]        float_resp_data_o,
  output logic                          float_resp_force_o,
  input  logic                          float_resp_yumi_i
);

  remote_req_if req_bus ();
  return_if     ret_bus ();

  // core side of the request bus
  assign req_bus.valid        = remote_req_v_i;
  assign req_bus.req          = remote_req_i;
  assign remote_req_credit_o  = req_bus.credit;

  return_fifo u_return_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_v_i     (ret_v_i),
    .in_ret_i   (ret_i),
    .in_ready_o (ret_ready_o),
    .q          (ret_bus.queue)
  );

  net_tx u_net_tx (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .req                (req_bus.tx),
    .ret                (ret_bus.tx),
    .tgo_x_i            (tgo_x_i),
    .tgo_y_i            (tgo_y_i),
    .my_x_i             (my_x_i),
    .my_y_i             (my_y_i),
    .pod_x_i            (pod_x_i),
    .pod_y_i            (pod_y_i),
    .cfg_pod_x_i        (cfg_pod_x_i),
    .cfg_pod_y_i        (cfg_pod_y_i),
    .out_credit_i       (out_credit_i),
    .out_packet_o       (out_packet_o),
    .out_v_o            (out_v_o),
    .invalid_eva_o      (invalid_eva_o),
    .ifetch_v_o         (ifetch_v_o),
    .ifetch_instr_o     (ifetch_instr_o),
    .int_resp_v_o       (int_resp_v_o),
    .int_resp_rd_o      (int_resp_rd_o),
    .int_resp_data_o    (int_resp_data_o),
    .int_resp_force_o   (int_resp_force_o),
    .int_resp_yumi_i    (int_resp_yumi_i),
    .float_resp_v_o     (float_resp_v_o),
    .float_resp_rd_o    (float_resp_rd_o),
    .float_resp_data_o  (float_resp_data_o),
    .float_resp_force_o (float_resp_force_o),
    .float_resp_yumi_i  (float_resp_yumi_i)
  );

endmodule

//--- include/net_consts.svh
// width, mesh size, vcache geometry and return queue depth constants
`ifndef NET_CONSTS_SVH
`define NET_CONSTS_SVH

// data and endpoint address
`define NET_DATA_W 32
`define NET_ADDR_W 28

// full coordinates are {pod, sub}
`define NET_X_W 7
`define NET_Y_W 7
`define NET_SUBX_W 4
`define NET_SUBY_W 3
`define NET_POD_X_W 3
`define NET_POD_Y_W 4

// tile array inside one pod
`define NET_TILES_X 16
`define NET_TILES_Y 8

`define NET_VC_BLOCK_WORDS 8
`define NET_REG_ID_W 5

`define RET_FIFO_DEPTH 4

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the endpoint testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f verilog.f --top-module tb_tile_net_endpoint -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without a failure"

//--- tb/net_stimulus.txt
# R kind(0 ld,1 st,2 amo) eva data mask reg_id load_info amo invalid | exp x y epa op
# P type(0 int,1 float,2 ifetch) data rd
# dram store and loads, ifetch uses the pod inputs
R 1 80000124 deadbeef f 00 00 0 0 59 28 0000001 1
R 0 80001040 00000000 0 00 12 0 0 22 10 0000040 0
R 0 80001040 00000000 0 03 02 0 0 52 28 0000040 0
# global float load and tile group store
R 0 45930124 00000000 0 07 0a 0 0 13 0b 0000049 0
R 1 208c0010 12345678 3 00 00 0 0 57 33 0000004 1
# atomics
R 2 45930124 00000011 0 01 02 0 0 13 0b 0000049 2
R 2 45930124 00000022 0 02 02 1 0 13 0b 0000049 3
R 2 45930124 00000033 0 03 02 2 0 13 0b 0000049 4
R 2 45930124 00000044 0 04 02 3 0 13 0b 0000049 5
R 2 45930124 00000055 0 05 02 4 0 13 0b 0000049 6
R 2 45930124 00000066 0 06 02 5 0 13 0b 0000049 7
R 2 45930124 00000077 0 07 02 6 0 13 0b 0000049 8
# invalid addresses
R 0 21c00000 00000000 0 04 02 0 1 00 00 0000000 0
R 1 20300000 cafef00d 1 00 00 0 1 00 00 0000000 1
R 0 00001000 00000000 0 02 02 0 1 00 00 0000000 0
# returns
P 0 a0000001 01
P 1 b0000002 02
P 2 00000013 00
P 0 a0000004 04
P 1 b0000005 05
P 0 a0000006 06
P 1 b0000007 07
P 0 a0000008 1f

//--- tb/tb_tile_net_endpoint.sv
// testbench for the tile network endpoint
// file driven requests and returns, queue reference model
`timescale 1ns/100ps
`include "net_consts.svh"

module tb_tile_net_endpoint;

  localparam int HALF       = 20;
  localparam int MAX_CYCLES = 200;
  localparam int MAX_LINES  = 200;

  logic                        clk_i;
  logic                        rst_n_i;
  core_req_pkg::remote_req_s   remote_req_i;
  logic                        remote_req_v_i;
  logic                        remote_req_credit_o;
  logic                        ret_v_i;
  net_pkg::net_ret_s           ret_i;
  logic                        ret_ready_o;
  logic [`NET_SUBX_W-1:0]      tgo_x_i;
  logic [`NET_SUBY_W-1:0]      tgo_y_i;
  logic [`NET_SUBX_W-1:0]      my_x_i;
  logic [`NET_SUBY_W-1:0]      my_y_i;
  logic [`NET_POD_X_W-1:0]     pod_x_i;
  logic [`NET_POD_Y_W-1:0]     pod_y_i;
  logic [`NET_POD_X_W-1:0]     cfg_pod_x_i;
  logic [`NET_POD_Y_W-1:0]     cfg_pod_y_i;
  logic                        out_credit_i;
  net_pkg::net_packet_s        out_packet_o;
  logic                        out_v_o;
  logic                        invalid_eva_o;
  logic                        ifetch_v_o;
  logic [`NET_DATA_W-1:0]      ifetch_instr_o;
  logic                        int_resp_v_o;
  logic [`NET_REG_ID_W-1:0]    int_resp_rd_o;
  logic [`NET_DATA_W-1:0]      int_resp_data_o;
  logic                        int_resp_force_o;
  logic                        int_resp_yumi_i;
  logic                        float_resp_v_o;
  logic [`NET_REG_ID_W-1:0]    float_resp_rd_o;
  logic [`NET_DATA_W-1:0]      float_resp_data_o;
  logic                        float_resp_force_o;
  logic                        float_resp_yumi_i;

  logic [31:0]                 lfsr_state;
  logic [31:0]                 fld [12];
  net_pkg::net_ret_s           resp_q [$];

  tile_net_endpoint DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #HALF clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_packet(input string name, input net_pkg::net_packet_s exp_v,
                              input net_pkg::net_packet_s act_v);
    if (act_v !== exp_v) begin
      stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      stop_on_error($sformatf("[ERROR] %s: expected %b, actual %b", name, exp_v, act_v));
    end
  endtask

  task automatic check_instr(input string name, input logic [`NET_DATA_W-1:0] exp_v,
                             input logic [`NET_DATA_W-1:0] act_v);
    if (act_v !== exp_v) begin
      stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp_v, act_v));
    end
  endtask

  // data, rd and force of one load response
  task automatic check_resp(input string name,
                            input logic [`NET_DATA_W-1:0] exp_data,
                            input logic [`NET_REG_ID_W-1:0] exp_rd, input logic exp_force,
                            input logic [`NET_DATA_W-1:0] act_data,
                            input logic [`NET_REG_ID_W-1:0] act_rd, input logic act_force);
    if ({act_data, act_rd, act_force} !== {exp_data, exp_rd, exp_force}) begin
      stop_on_error($sformatf("[ERROR] %s: expected %h/%h/%b, actual %h/%h/%b", name,
                              exp_data, exp_rd, exp_force, act_data, act_rd, act_force));
    end
  endtask

  // galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic lfsr_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  // fld: kind eva data mask reg info amo inv | x y epa op
  task automatic drive_request(input int idx);
    net_pkg::net_packet_s exp_pkt;
    string                name;
    name = $sformatf("request %0d", idx);
    @(negedge clk_i);
    remote_req_i.write_not_read = (fld[0] == 1);
    remote_req_i.is_amo_op      = (fld[0] == 2);
    remote_req_i.amo_type       = core_req_pkg::amo_e'(fld[6][2:0]);
    remote_req_i.mask           = fld[3][3:0];
    remote_req_i.reg_id         = fld[4][4:0];
    remote_req_i.load_info      = fld[5][4:0];
    remote_req_i.addr           = fld[1];
    remote_req_i.data           = fld[2];
    remote_req_v_i              = 1'b1;
    out_credit_i                = ~out_credit_i;
    #5;
    // loads send load info, stores send the mask as reg id
    exp_pkt.payload = (fld[0] == 0) ? `NET_DATA_W'(fld[5][4:0]) : fld[2];
    exp_pkt.reg_id  = (fld[0] == 1) ? `NET_REG_ID_W'(fld[3][3:0]) : fld[4][4:0];
    exp_pkt.src_y   = {pod_y_i, my_y_i};
    exp_pkt.src_x   = {pod_x_i, my_x_i};
    exp_pkt.x       = fld[8][6:0];
    exp_pkt.y       = fld[9][6:0];
    exp_pkt.addr    = fld[10][27:0];
    exp_pkt.op      = net_pkg::net_op_e'(fld[11][3:0]);
    check_flag({name, " credit"}, out_credit_i, remote_req_credit_o);
    check_flag({name, " out_v"}, ~fld[7][0], out_v_o);
    check_flag({name, " invalid_eva"}, fld[7][0], invalid_eva_o);
    if (!fld[7][0]) begin
      check_packet({name, " packet"}, exp_pkt, out_packet_o);
    end
  endtask

  // pushes every return, models the queue and checks dispatch each cycle
  task automatic run_returns(input logic hold_yumi);
    net_pkg::net_ret_s push_q [$];
    net_pkg::net_ret_s model_q [$];
    net_pkg::net_ret_s head;
    logic              has;
    logic              full;
    logic              hold;
    logic              int_b;
    logic              float_b;
    logic              popped;
    logic              saw_force;
    int                cycles;
    push_q    = resp_q;
    saw_force = 1'b0;
    cycles    = 0;
    while (push_q.size() > 0 || model_q.size() > 0) begin
      if (cycles == MAX_CYCLES) begin
        stop_on_error("return queue did not drain before the timeout");
      end
      cycles++;
      @(negedge clk_i);
      has  = (model_q.size() > 0);
      head = has ? model_q[0] : '0;
      full = (model_q.size() == `RET_FIFO_DEPTH);
      hold = hold_yumi && (push_q.size() > 0);
      lfsr_bit(int_b);
      lfsr_bit(float_b);
      int_resp_yumi_i   = !hold && int_b && has && (head.pkt_type == net_pkg::e_ret_int_wb);
      float_resp_yumi_i = !hold && float_b && has &&
                          (head.pkt_type == net_pkg::e_ret_float_wb);
      ret_v_i = (push_q.size() > 0);
      if (ret_v_i) begin
        ret_i = push_q[0];
      end
      #5;
      check_flag("ret_ready", ~full, ret_ready_o);
      check_flag("ifetch_v", has && head.pkt_type == net_pkg::e_ret_ifetch, ifetch_v_o);
      check_flag("int_resp_v", has && head.pkt_type == net_pkg::e_ret_int_wb, int_resp_v_o);
      check_flag("float_resp_v", has && head.pkt_type == net_pkg::e_ret_float_wb,
                 float_resp_v_o);
      popped = 1'b0;
      if (has) begin
        case (head.pkt_type)
          net_pkg::e_ret_ifetch: begin
            check_instr("ifetch instr", head.data, ifetch_instr_o);
            popped = 1'b1;
          end
          net_pkg::e_ret_float_wb: begin
            check_resp("float resp", head.data, head.reg_id, full,
                       float_resp_data_o, float_resp_rd_o, float_resp_force_o);
            popped = float_resp_yumi_i | full;
          end
          default: begin
            check_resp("int resp", head.data, head.reg_id, full,
                       int_resp_data_o, int_resp_rd_o, int_resp_force_o);
            popped = int_resp_yumi_i | full;
          end
        endcase
      end
      saw_force = saw_force | int_resp_force_o | float_resp_force_o;
      if (popped) begin
        void'(model_q.pop_front());
      end
      if (ret_v_i && !full) begin
        model_q.push_back(push_q.pop_front());
      end
    end
    @(negedge clk_i);
    ret_v_i           = 1'b0;
    int_resp_yumi_i   = 1'b0;
    float_resp_yumi_i = 1'b0;
    if (hold_yumi) begin
      check_flag("queue filled and forced", 1'b1, saw_force);
    end
  endtask

  initial begin
    int                  fd;
    int                  code;
    int                  ch;
    int                  n_req;
    logic [8*8-1:0]      tag;
    net_pkg::net_ret_s   r;
    rst_n_i           = 1'b0;
    remote_req_i      = '0;
    remote_req_v_i    = 1'b0;
    ret_v_i           = 1'b0;
    ret_i             = '0;
    int_resp_yumi_i   = 1'b0;
    float_resp_yumi_i = 1'b0;
    out_credit_i      = 1'b0;
    tgo_x_i           = 4'd4;
    tgo_y_i           = 3'd1;
    my_x_i            = 4'd1;
    my_y_i            = 3'd2;
    pod_x_i           = 3'd2;
    pod_y_i           = 4'd3;
    cfg_pod_x_i       = 3'd5;
    cfg_pod_y_i       = 4'd6;
    lfsr_state        = 32'he0978043;
    n_req             = 0;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #5;
    check_flag("reset ret_ready", 1'b1, ret_ready_o);
    check_flag("reset valids", 1'b0, ifetch_v_o | int_resp_v_o | float_resp_v_o);
    check_flag("reset force", 1'b0, int_resp_force_o | float_resp_force_o);
    check_flag("reset invalid_eva", 1'b0, invalid_eva_o);

    fd = $fopen("tb/net_stimulus.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open the stimulus file tb/net_stimulus.txt");
    end
    for (int line = 0; line < MAX_LINES; line++) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "R") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                       fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9], fld[10],
                       fld[11]);
        if (code != 12) begin
          stop_on_error("a request line in the stimulus file is malformed");
        end
        drive_request(n_req);
        n_req++;
      end else if (tag == "P") begin
        code = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
        if (code != 3) begin
          stop_on_error("a response line in the stimulus file is malformed");
        end
        r.pkt_type = net_pkg::net_ret_type_e'(fld[0][1:0]);
        r.data     = fld[1];
        r.reg_id   = fld[2][4:0];
        resp_q.push_back(r);
      end else begin
        // comment line
        ch = 0;
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end
    end
    $fclose(fd);

    @(negedge clk_i);
    remote_req_v_i = 1'b0;
    #5;
    check_flag("idle out_v", 1'b0, out_v_o);
    check_flag("idle invalid_eva", 1'b0, invalid_eva_o);

    run_returns(1'b0);
    run_returns(1'b1);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
hdl/net_pkg.sv
hdl/core_req_pkg.sv
hdl/net_ifs.sv
hdl/eva_to_npa.sv
hdl/net_tx.sv
hdl/return_fifo.sv
hdl/tile_net_endpoint.sv
tb/tb_tile_net_endpoint.sv
